//--- game_logic.f
common/game_pkg.sv
common/game_ctrl_if.sv
logic/key_conditioner.sv
game_controller/game_controller.sv
logic/monster_wave.sv
logic/player_lives.sv
logic/game_top.sv
tb/game_top_tb.sv

//--- Bender.yml
package:
  name: game_logic

sources:
  - files:
      - common/game_pkg.sv
      - common/game_ctrl_if.sv
      - logic/key_conditioner.sv
      - game_controller/game_controller.sv
      - logic/monster_wave.sv
      - logic/player_lives.sv
      - logic/game_top.sv
  - target: test
    files:
      - tb/game_top_tb.sv

//--- tb/game_tests.txt
# columns: name op arg stage monsters lives enable game_won game_over
# arg is the count for hit_monster, hit_player and wait, 0 for the other operations
after_reset        wait         0  0  4 3 0 0 0
start_game         start        0  0  4 3 1 0 0
clear_wave0        hit_monster  5  1  6 3 1 0 0
pause_enter        pause_on     0  1  6 3 0 0 0
pause_mhits        hit_monster  2  1  6 3 0 0 0
pause_phit         hit_player   1  1  6 3 0 0 0
pause_leave        pause_off    0  1  6 3 1 0 0
resume_mhit        hit_monster  1  1  5 3 1 0 0
resume_phit        hit_player   1  1  5 2 1 0 0
skip_to_2          skip         0  2  8 2 1 0 0
skip_to_3          skip         0  3 10 2 1 0 0
skip_last_ignored  skip         0  3 10 2 1 0 0
partial_wave3      hit_monster  6  3  4 2 1 0 0
clear_wave3        hit_monster  4  3  0 2 0 1 0
won_hold           wait        20  3  0 2 0 1 0
won_hits_ignored   hit_monster  2  3  0 2 0 1 0
reset_after_win    reset        0  0  4 3 0 0 0
restart            start        0  0  4 3 1 0 0
lose_two_lives     hit_player   2  0  4 1 1 0 0
lose_last_life     hit_player   1  0  4 0 0 0 1
over_phits_ignored hit_player   2  0  4 0 0 0 1
over_mhit_ignored  hit_monster  1  0  4 0 0 0 1
over_start_ignored start        0  0  4 0 0 0 1
over_hold          wait        20  0  4 0 0 0 1
reset_after_loss   reset        0  0  4 3 0 0 0

//--- tb/game_top_tb.sv
/*
 * game logic testbench
 * reads the test table, drives game_top and checks its outputs after each step
 */
`timescale 1ns/1ps
`default_nettype none

module game_top_tb;

	localparam int    CLK_PERIOD  = 4;	// ns
	localparam int    DRIVE_DELAY = 1;	// ns after the rising edge
	localparam int    SETTLE      = 5;	// cycles before each check
	localparam int    TEST_BUDGET = 100;	// watchdog cycles per test
	localparam string TEST_FILE   = "tb/game_tests.txt";

	logic                           clk;
	logic                           resetN;
	logic                           start_key;
	logic                           skip_key;
	logic                           pause_sw;
	logic                           monster_hit;
	logic                           player_hit;
	logic                           enable_player;
	logic                           enable_monsters;
	logic                           game_won;
	logic                           game_over;
	game_pkg::stage_t               stage_num;
	logic [game_pkg::MONSTER_W-1:0] monsters_left;
	logic [game_pkg::LIVES_W-1:0]   lives;

	string t_name[$];
	string t_op[$];
	int    t_arg[$];
	int    t_stage[$];
	int    t_mons[$];
	int    t_lives[$];
	int    t_en[$];
	int    t_won[$];
	int    t_over[$];

	logic  tests_loaded;
	int    load_errors;
	int    error_count;
	int    errs_before;
	int    tests_ok;
	int    tests_bad;

	game_top dut (
		.clk             (clk),
		.resetN          (resetN),
		.start_key       (start_key),
		.skip_key        (skip_key),
		.pause_sw        (pause_sw),
		.monster_hit     (monster_hit),
		.player_hit      (player_hit),
		.enable_player   (enable_player),
		.enable_monsters (enable_monsters),
		.game_won        (game_won),
		.game_over       (game_over),
		.stage_num       (stage_num),
		.monsters_left   (monsters_left),
		.lives           (lives)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task next_cycle;
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task wait_cycles(input int n);
		repeat (n) next_cycle;
	endtask

	task press_start;
		start_key = 1'b1;
		next_cycle;
		start_key = 1'b0;
	endtask

	task press_skip;
		skip_key = 1'b1;
		next_cycle;
		skip_key = 1'b0;
	endtask

	task hit_monsters(input int n);
		repeat (n) begin
			monster_hit = 1'b1;	// one-cycle pulse and a one-cycle gap
			next_cycle;
			monster_hit = 1'b0;
			next_cycle;
		end
	endtask

	task hit_player_n(input int n);
		repeat (n) begin
			player_hit = 1'b1;
			next_cycle;
			player_hit = 1'b0;
			next_cycle;
		end
	endtask

	task apply_reset;
		resetN = 1'b0;
		wait_cycles(5);
		resetN = 1'b1;
	endtask

	task load_tests;
		int    fd;
		int    n;
		string line;
		string name;
		string op;
		int    arg;
		int    s;
		int    m;
		int    l;
		int    e;
		int    w;
		int    o;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the test file %s", TEST_FILE);
			load_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin	// skip notes
					n = $sscanf(line, "%s %s %d %d %d %d %d %d %d",
						name, op, arg, s, m, l, e, w, o);
					if (n == 9) begin
						t_name.push_back(name);
						t_op.push_back(op);
						t_arg.push_back(arg);
						t_stage.push_back(s);
						t_mons.push_back(m);
						t_lives.push_back(l);
						t_en.push_back(e);
						t_won.push_back(w);
						t_over.push_back(o);
					end else begin
						$display("malformed line in the test file: %s", line);
						load_errors++;
					end
				end
			end
			$fclose(fd);
		end
		if (t_name.size() == 0) begin
			$display("no tests were found in %s", TEST_FILE);
			load_errors++;
		end
	endtask

	task run_op(input string test, input string op, input int arg);
		case (op)
			"start":       press_start;
			"skip":        press_skip;
			"pause_on":    pause_sw = 1'b1;
			"pause_off":   pause_sw = 1'b0;
			"hit_monster": hit_monsters(arg);
			"hit_player":  hit_player_n(arg);
			"wait":        wait_cycles(arg);
			"reset":       apply_reset;
			default: begin
				$display("test %s uses an unknown operation %s", test, op);
				error_count++;
			end
		endcase
	endtask

	task check_field(input string test, input string field, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			$display("FAIL %s: %s expected %0d actual %0d", test, field, exp, act);
			error_count++;
		end
	endtask

	// watchdog with one spare budget for the reset phase
	initial begin
		wait (tests_loaded === 1'b1);
		#((t_name.size() + 1) * TEST_BUDGET * CLK_PERIOD);
		$display("run timed out before all %0d tests finished", t_name.size());
		$display("Verification failed");
		$finish;
	end

	initial begin
		tests_loaded = 1'b0;
		load_errors  = 0;
		error_count  = 0;
		tests_ok     = 0;
		tests_bad    = 0;
		resetN       = 1'b0;
		start_key    = 1'b0;
		skip_key     = 1'b0;
		pause_sw     = 1'b0;
		monster_hit  = 1'b0;
		player_hit   = 1'b0;
		load_tests;
		tests_loaded = 1'b1;
		wait_cycles(5);
		resetN = 1'b1;
		for (int i = 0; i < t_name.size(); i++) begin
			errs_before = error_count;
			run_op(t_name[i], t_op[i], t_arg[i]);
			wait_cycles(SETTLE);
			check_field(t_name[i], "stage_num", t_stage[i], stage_num);
			check_field(t_name[i], "monsters_left", t_mons[i], monsters_left);
			check_field(t_name[i], "lives", t_lives[i], lives);
			check_field(t_name[i], "enable_player", t_en[i], enable_player);
			check_field(t_name[i], "enable_monsters", t_en[i], enable_monsters);
			check_field(t_name[i], "game_won", t_won[i], game_won);
			check_field(t_name[i], "game_over", t_over[i], game_over);
			if (error_count == errs_before) begin
				$display("test %0d %s ok", i, t_name[i]);
				tests_ok++;
			end else begin
				$display("test %0d %s had %0d errors, controller state %0d",
					i, t_name[i], error_count - errs_before, dut.u_ctrl.state);
				tests_bad++;
			end
		end
		$display("tests %0d, ok %0d, with errors %0d, load errors %0d",
			t_name.size(), tests_ok, tests_bad, load_errors);
		if (error_count == 0 && load_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/game_top.sv
/*
 * game logic top
 * key conditioner, game controller, monster wave and player lives
 * joined over the control bus
 */
`timescale 1ns/1ps
`default_nettype none

module game_top (
	input  logic                          clk,
	input  logic                          resetN,
	input  logic                          start_key,
	input  logic                          skip_key,
	input  logic                          pause_sw,
	input  logic                          monster_hit,
	input  logic                          player_hit,
	output logic                          enable_player,
	output logic                          enable_monsters,
	output logic                          game_won,
	output logic                          game_over,
	output game_pkg::stage_t              stage_num,
	output logic [game_pkg::MONSTER_W-1:0] monsters_left,
	output logic [game_pkg::LIVES_W-1:0]   lives
);

	logic start_pulse;
	logic skip_pulse;
	logic pause_level;
	logic win_stage;
	logic player_destroyed;

	game_ctrl_if ctrl_bus ();

	key_conditioner u_keys (
		.clk         (clk),
		.resetN      (resetN),
		.start_key   (start_key),
		.skip_key    (skip_key),
		.pause_sw    (pause_sw),
		.start_pulse (start_pulse),
		.skip_pulse  (skip_pulse),
		.pause_level (pause_level)
	);

	game_controller u_ctrl (
		.clk              (clk),
		.resetN           (resetN),
		.start_pulse      (start_pulse),
		.skip_pulse       (skip_pulse),
		.pause_level      (pause_level),
		.win_stage        (win_stage),
		.player_destroyed (player_destroyed),
		.ctrl             (ctrl_bus),
		.game_won         (game_won),
		.game_over        (game_over)
	);

	monster_wave u_wave (
		.clk           (clk),
		.resetN        (resetN),
		.ctrl          (ctrl_bus),
		.monster_hit   (monster_hit),
		.monsters_left (monsters_left),
		.win_stage     (win_stage)
	);

	player_lives u_lives (
		.clk              (clk),
		.resetN           (resetN),
		.ctrl             (ctrl_bus),
		.player_hit       (player_hit),
		.lives            (lives),
		.player_destroyed (player_destroyed)
	);

	// bus signals out to the board
	assign enable_player   = ctrl_bus.enable_player;
	assign enable_monsters = ctrl_bus.enable_monsters;
	assign stage_num       = ctrl_bus.stage_num;

endmodule

`default_nettype wire

//--- logic/player_lives.sv
/*
 * player lives counter
 * decrements on player hits, flags when no lives remain
 */
`timescale 1ns/1ps
`default_nettype none

module player_lives (
	input  logic                        clk,
	input  logic                        resetN,
	game_ctrl_if.player                 ctrl,
	input  logic                        player_hit,
	output logic [game_pkg::LIVES_W-1:0] lives,
	output logic                        player_destroyed
);

	logic hit_ok;

	assign hit_ok = ctrl.enable_player && player_hit && (lives != '0);	// no wrap at zero

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lives <= game_pkg::LIVES_START;
		end else if (!ctrl.resetN_player) begin
			lives <= game_pkg::LIVES_START;	// reload at game start
		end else if (hit_ok) begin
			lives <= lives - 1'b1;
		end
	end

	assign player_destroyed = (lives == '0);

	// lives only go up on a reload
	a_lives_rise: assert property (@(posedge clk) disable iff (!resetN)
		(lives > $past(lives)) |-> !$past(ctrl.resetN_player));

endmodule

`default_nettype wire

//--- logic/monster_wave.sv
/*
 * monster wave counter
 * counts monsters left in the stage, reloads per stage, flags a cleared wave
 */
`timescale 1ns/1ps
`default_nettype none

module monster_wave (
	input  logic                          clk,
	input  logic                          resetN,
	game_ctrl_if.wave                     ctrl,
	input  logic                          monster_hit,
	output logic [game_pkg::MONSTER_W-1:0] monsters_left,
	output logic                          win_stage
);

	logic reload;	// sync reload request from controller
	logic hit_ok;	// hit counts this cycle

	assign reload = !ctrl.resetN_monsters;
	assign hit_ok = ctrl.enable_monsters && monster_hit && (monsters_left != '0);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			monsters_left <= game_pkg::WAVE_SIZE[0];	// stage 0 wave
		end else if (reload) begin
			monsters_left <= game_pkg::WAVE_SIZE[ctrl.stage_num];
		end else if (hit_ok) begin
			monsters_left <= monsters_left - 1'b1;
		end
	end

	// cleared only once no reload is pending
	assign win_stage = (monsters_left == '0) && !reload;

	// count stays within the current stage's wave
	a_wave_bound: assert property (@(posedge clk) disable iff (!resetN)
		monsters_left <= game_pkg::WAVE_SIZE[ctrl.stage_num]);

endmodule

`default_nettype wire

//--- game_controller/game_controller.sv
/*
 * game controller
 * top-level game FSM: start, run, pause, stage advance, win or lose
 * keeps the stage number and drives the unit enables and reloads
 */
`timescale 1ns/1ps
`default_nettype none

module game_controller (
	input  logic   clk,
	input  logic   resetN,
	input  logic   start_pulse,
	input  logic   skip_pulse,
	input  logic   pause_level,
	input  logic   win_stage,
	input  logic   player_destroyed,
	game_ctrl_if.controller ctrl,
	output logic   game_won,
	output logic   game_over
);

	game_pkg::ctrl_state_t state, state_nxt;
	game_pkg::stage_t      stage, stage_nxt;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= game_pkg::RESET;
			stage <= '0;
		end else begin
			state <= state_nxt;
			stage <= stage_nxt;
		end
	end

	// next state and stage
	always_comb begin
		state_nxt = state;
		stage_nxt = stage;
		case (state)
			game_pkg::RESET: begin
				stage_nxt = '0;
				if (start_pulse)
					state_nxt = game_pkg::RUN;
			end
			game_pkg::RUN: begin
				if (pause_level)
					state_nxt = game_pkg::PAUSE;
				else if (player_destroyed)
					state_nxt = game_pkg::GAME_OVER;
				else if (skip_pulse && stage != game_pkg::LAST_STAGE)
					state_nxt = game_pkg::STAGE_WON;	// skip ignored on last stage
				else if (win_stage)
					state_nxt = game_pkg::STAGE_WON;
			end
			game_pkg::PAUSE: begin
				if (!pause_level)
					state_nxt = game_pkg::RUN;
			end
			game_pkg::STAGE_WON: begin
				if (stage == game_pkg::LAST_STAGE) begin
					state_nxt = game_pkg::GAME_WON;
				end else begin
					stage_nxt = game_pkg::stage_t'(stage + 1'b1);
					state_nxt = game_pkg::LOAD;
				end
			end
			game_pkg::LOAD: begin
				state_nxt = game_pkg::RUN;	// wave reloaded for new stage
			end
			game_pkg::GAME_OVER,
			game_pkg::GAME_WON: begin
				state_nxt = state;	// held until resetN
			end
			default: begin
				state_nxt = game_pkg::RESET;
			end
		endcase
	end

	// output decode from state only
	always_comb begin
		ctrl.enable_player   = 1'b0;
		ctrl.enable_monsters = 1'b0;
		ctrl.resetN_player   = 1'b1;
		ctrl.resetN_monsters = 1'b1;
		game_won             = 1'b0;
		game_over            = 1'b0;
		case (state)
			game_pkg::RESET: begin
				ctrl.resetN_player   = 1'b0;
				ctrl.resetN_monsters = 1'b0;
			end
			game_pkg::RUN: begin
				ctrl.enable_player   = 1'b1;
				ctrl.enable_monsters = 1'b1;
			end
			game_pkg::LOAD:      ctrl.resetN_monsters = 1'b0;
			game_pkg::GAME_OVER: game_over = 1'b1;
			game_pkg::GAME_WON:  game_won = 1'b1;
			default: ;
		endcase
	end

	assign ctrl.stage_num = stage;

	// end flags are exclusive
	a_end_flags: assert property (@(posedge clk) disable iff (!resetN)
		!(game_won && game_over));

	// stage only moves on a stage win or during reset
	a_stage_change: assert property (@(posedge clk) disable iff (!resetN)
		$changed(stage) |-> ($past(state) inside {game_pkg::STAGE_WON, game_pkg::RESET}));

endmodule

`default_nettype wire

//--- logic/key_conditioner.sv
/*
 * key conditioner
 * synchronizes board keys and pause switch, one pulse per key press
 */
`timescale 1ns/1ps
`default_nettype none

module key_conditioner (
	input  logic clk,
	input  logic resetN,
	input  logic start_key,
	input  logic skip_key,
	input  logic pause_sw,
	output logic start_pulse,
	output logic skip_pulse,
	output logic pause_level
);

	logic [2:0] in_meta;	// {pause, skip, start}
	logic [2:0] in_sync;
	logic [1:0] key_prev;	// last synced keys for edge detect

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			in_meta  <= '0;
			in_sync  <= '0;
			key_prev <= '0;
		end else begin
			in_meta  <= {pause_sw, skip_key, start_key};
			in_sync  <= in_meta;
			key_prev <= in_sync[1:0];
		end
	end

	assign start_pulse = in_sync[0] & ~key_prev[0];	// rising edge only
	assign skip_pulse  = in_sync[1] & ~key_prev[1];
	assign pause_level = in_sync[2];

endmodule

`default_nettype wire

//--- common/game_ctrl_if.sv
/*
 * game control bus
 * enables, unit reload requests and stage number from the controller
 */
`timescale 1ns/1ps
`default_nettype none

interface game_ctrl_if;

	logic             enable_player;
	logic             enable_monsters;
	logic             resetN_player;	// active-low sync reload request
	logic             resetN_monsters;	// active-low sync reload request
	game_pkg::stage_t stage_num;

	modport controller (
		output enable_player, enable_monsters,
		output resetN_player, resetN_monsters,
		output stage_num
	);

	modport wave (input enable_monsters, resetN_monsters, stage_num);

	modport player (input enable_player, resetN_player);

endinterface

`default_nettype wire

//--- common/game_pkg.sv
/*
 * game package
 * stage and controller state types, wave sizes and lives constants
 * shared by the game logic core
 */
`default_nettype none

package game_pkg;

	localparam int NUM_STAGES = 4;
	localparam int MONSTER_W  = 4;	// monster count width
	localparam int LIVES_W    = 2;	// lives count width

	typedef logic [1:0] stage_t;	// stages 0..3

	typedef enum logic [2:0] {
		RESET,
		RUN,
		PAUSE,
		STAGE_WON,
		LOAD,
		GAME_OVER,
		GAME_WON
	} ctrl_state_t;

	localparam stage_t LAST_STAGE = stage_t'(NUM_STAGES - 1);

	// monsters per wave, indexed by stage
	localparam logic [MONSTER_W-1:0] WAVE_SIZE [NUM_STAGES] = '{
		4'd4,
		4'd6,
		4'd8,
		4'd10
	};

	localparam logic [LIVES_W-1:0] LIVES_START = 2'd3;

endpackage

`default_nettype wire
